// ==== csr_file.f ====
src/csr_pkg.sv
src/csr_req_if.sv
src/csr_access_check.sv
src/csr_read_path.sv
src/csr_status_reg.sv
src/csr_trap_regs.sv
src/csr_fp_regs.sv
src/csr_file.sv
verif/csr_tb_clock.sv
verif/csr_file_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR block testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f csr_file.f --top-module csr_file_tb \
  -o csr_file_sim \
  && ./obj_dir/csr_file_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run error"; exit 1; }

cat sim.log
# The testbench prints its fail message on any error or timeout
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== src/csr_access_check.sv ====
/*
 * CSR access checker. Flags accesses to missing addresses, accesses
 * above the current privilege and writes to read-only registers, and
 * produces the write commit for the register modules.
 */
module csr_access_check (
  csr_req_if.check       req,
  input  logic           csr_we,
  input  logic           csr_access,    // CSR instruction active
  input  csr_pkg::priv_e current_priv,
  output logic           illegal_csr
);
  import csr_pkg::*;

  logic       exists;
  logic       priv_ok;
  logic       read_only;
  logic [1:0] addr_priv;

  // ==================================================
  // Address decode
  // ==================================================
  always_comb begin
    case (req.addr)
      CSR_FFLAGS, CSR_FRM, CSR_FCSR,
      CSR_SSTATUS, CSR_STVEC, CSR_SSCRATCH,
      CSR_SEPC, CSR_SCAUSE, CSR_STVAL,
      CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL,
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:
        exists = 1'b1;
      default:
        exists = 1'b0;
    endcase
  end

  assign addr_priv = req.addr[9:8];             // Lowest privilege allowed
  assign priv_ok   = (current_priv >= addr_priv);

  // Top bits 11 mark read-only space, misa is hardwired as well
  assign read_only = (req.addr[11:10] == 2'b11) || (req.addr == CSR_MISA);

  // ==================================================
  // Results
  // ==================================================
  // Existence and privilege apply to reads too, read-only only to writes
  assign illegal_csr = csr_access && (!exists || !priv_ok || (csr_we && read_only));

  assign req.commit = csr_we && !read_only;

endmodule

// ==== src/csr_file.sv ====
/*
 * CSR block top level for an RV32 core. Connects the request
 * interface, access checker, read path and the register modules.
 */
module csr_file (
  input  logic           clk,
  input  logic           reset_n,
  input  logic [11:0]    csr_addr,
  input  csr_pkg::word_t csr_wdata,      // rs1 or uimm
  input  logic [2:0]     csr_op,         // funct3
  input  logic           csr_we,
  input  logic           csr_access,
  output csr_pkg::word_t csr_rdata,
  output logic           illegal_csr,
  input  logic           trap_entry,
  input  csr_pkg::word_t trap_pc,
  input  logic [4:0]     trap_cause,
  input  csr_pkg::word_t trap_val,
  output csr_pkg::word_t trap_vector,
  output logic [1:0]     trap_target_priv,
  input  logic           mret,
  input  logic           sret,
  input  logic [1:0]     current_priv,
  output csr_pkg::word_t mepc_out,
  output csr_pkg::word_t sepc_out,
  output logic           mstatus_mie,
  output logic [1:0]     mpp_out,
  output logic           spp_out,
  input  logic           fflags_we,
  input  logic [4:0]     fflags_in,
  output logic [2:0]     frm_out,
  output logic [4:0]     fflags_out
);
  import csr_pkg::*;

  csr_req_if req_if ();

  word_t               mstatus_val;
  word_t               trap_rdata;
  logic                trap_hit;
  logic [FFLAGS_W-1:0] fflags_now;
  logic                m_entry;
  logic                s_entry;
  priv_e               cur_priv;
  priv_e               target_priv;

  assign req_if.addr      = csr_addr;
  assign req_if.wdata     = csr_wdata;
  assign req_if.op        = csr_op_e'(csr_op);
  assign csr_rdata        = req_if.rdata;
  assign cur_priv         = priv_e'(current_priv);
  assign trap_target_priv = target_priv;

  csr_access_check u_check (
    .req(req_if), .csr_we(csr_we), .csr_access(csr_access),
    .current_priv(cur_priv), .illegal_csr(illegal_csr)
  );

  csr_read_path u_read (
    .req(req_if), .mstatus_val(mstatus_val), .trap_rdata(trap_rdata),
    .trap_hit(trap_hit), .fflags_now(fflags_now), .frm(frm_out)
  );

  csr_status_reg u_status (
    .clk(clk), .reset_n(reset_n), .req(req_if), .m_entry(m_entry), .s_entry(s_entry),
    .mret(mret), .sret(sret), .current_priv(cur_priv), .mstatus_val(mstatus_val),
    .mstatus_mie(mstatus_mie), .mpp_out(mpp_out), .spp_out(spp_out)
  );

  csr_trap_regs u_trap (
    .clk(clk), .reset_n(reset_n), .req(req_if), .trap_entry(trap_entry),
    .trap_pc(trap_pc), .trap_cause(trap_cause), .trap_val(trap_val),
    .current_priv(cur_priv), .trap_target_priv(target_priv), .trap_vector(trap_vector),
    .mepc_out(mepc_out), .sepc_out(sepc_out), .m_entry(m_entry), .s_entry(s_entry),
    .trap_rdata(trap_rdata), .trap_hit(trap_hit)
  );

  csr_fp_regs u_fp (
    .clk(clk), .reset_n(reset_n), .req(req_if), .fflags_we(fflags_we),
    .fflags_in(fflags_in), .fflags_now(fflags_now), .frm_out(frm_out),
    .fflags_out(fflags_out)
  );

endmodule

// ==== src/csr_fp_regs.sv ====
/*
 * Floating-point CSRs: rounding mode and sticky exception flags.
 * The FPU ORs new flags in; reads see them in the same cycle.
 */
module csr_fp_regs (
  input  logic                         clk,
  input  logic                         reset_n,
  csr_req_if.reg_side                  req,
  input  logic                         fflags_we,   // FPU accumulate strobe
  input  logic [csr_pkg::FFLAGS_W-1:0] fflags_in,
  output logic [csr_pkg::FFLAGS_W-1:0] fflags_now,  // Forwarded for reads
  output logic [csr_pkg::FRM_W-1:0]    frm_out,
  output logic [csr_pkg::FFLAGS_W-1:0] fflags_out
);
  import csr_pkg::*;

  logic [FFLAGS_W-1:0] fflags_r;
  logic [FRM_W-1:0]    frm_r;
  logic                fflags_wr;

  assign fflags_now = fflags_we ? (fflags_r | fflags_in) : fflags_r;

  // CSR write beats accumulation
  assign fflags_wr = req.commit && (req.addr == CSR_FFLAGS || req.addr == CSR_FCSR);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags_r <= '0;
      frm_r    <= '0;  // RNE
    end else begin
      if (fflags_wr) begin
        fflags_r <= req.write_value[FFLAGS_W-1:0];
      end else if (fflags_we) begin
        fflags_r <= fflags_now;  // Sticky OR
      end
      if (req.commit && req.addr == CSR_FRM) begin
        frm_r <= req.write_value[FRM_W-1:0];
      end else if (req.commit && req.addr == CSR_FCSR) begin
        frm_r <= req.write_value[FFLAGS_W+FRM_W-1:FFLAGS_W];  // Bits 7:5
      end
    end
  end

  assign frm_out    = frm_r;
  assign fflags_out = fflags_r;

endmodule

// ==== src/csr_pkg.sv ====
/*
 * CSR package for the RV32 control and status register block.
 * Holds register widths, CSR addresses, funct3 operation and privilege
 * encodings, mstatus bit positions and hardwired register values.
 */
package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;  // One register word

  // ==================================================
  // CSR addresses
  // ==================================================
  typedef enum logic [11:0] {
    // Floating-point
    CSR_FFLAGS    = 12'h001,
    CSR_FRM       = 12'h002,
    CSR_FCSR      = 12'h003,
    // Supervisor trap setup and handling
    CSR_SSTATUS   = 12'h100,
    CSR_STVEC     = 12'h105,
    CSR_SSCRATCH  = 12'h140,
    CSR_SEPC      = 12'h141,
    CSR_SCAUSE    = 12'h142,
    CSR_STVAL     = 12'h143,
    // Machine trap setup and handling
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MEDELEG   = 12'h302,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    // Machine information, read-only
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // CSR instruction funct3
  typedef enum logic [2:0] {
    CSR_RW  = 3'd1,
    CSR_RS  = 3'd2,
    CSR_RC  = 3'd3,
    CSR_RWI = 3'd5,
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  // ==================================================
  // mstatus fields and constants
  // ==================================================
  localparam int MSTATUS_SIE     = 1;
  localparam int MSTATUS_MIE     = 3;
  localparam int MSTATUS_SPIE    = 5;
  localparam int MSTATUS_MPIE    = 7;
  localparam int MSTATUS_SPP     = 8;
  localparam int MSTATUS_MPP_LSB = 11;  // MPP is two bits wide

  localparam word_t SSTATUS_MASK  = 32'h0000_0122;  // SIE, SPIE, SPP
  localparam word_t MSTATUS_RESET = 32'h0000_1800;  // MPP = M
  localparam word_t MISA_VALUE    = 32'h4000_1129;  // MXL=1, IMAFD
  localparam word_t MIMPID_VALUE  = 32'h0000_0001;

  localparam int FFLAGS_W = 5;  // NV DZ OF UF NX
  localparam int FRM_W    = 3;

endpackage

// ==== src/csr_read_path.sv ====
/*
 * CSR read multiplexer and write value computation.
 * Register values come in from the register modules; the write value
 * is the read data replaced, ORed or cleared by the operand.
 */
module csr_read_path (
  csr_req_if.read                    req,
  input  csr_pkg::word_t             mstatus_val,
  input  csr_pkg::word_t             trap_rdata,  // From trap registers
  input  logic                       trap_hit,    // Address is a trap register
  input  logic [csr_pkg::FFLAGS_W-1:0] fflags_now,  // Already forwarded
  input  logic [csr_pkg::FRM_W-1:0]    frm
);
  import csr_pkg::*;

  word_t rd;

  // ==================================================
  // Read mux
  // ==================================================
  always_comb begin
    case (req.addr)
      CSR_MSTATUS:   rd = mstatus_val;
      CSR_SSTATUS:   rd = mstatus_val & SSTATUS_MASK;  // S-mode view
      CSR_MISA:      rd = MISA_VALUE;
      CSR_MIMPID:    rd = MIMPID_VALUE;
      CSR_MVENDORID: rd = '0;  // Not implemented
      CSR_MARCHID:   rd = '0;
      CSR_MHARTID:   rd = '0;  // Single hart
      CSR_FFLAGS:    rd = {{(XLEN-FFLAGS_W){1'b0}}, fflags_now};
      CSR_FRM:       rd = {{(XLEN-FRM_W){1'b0}}, frm};
      CSR_FCSR:      rd = {{(XLEN-FRM_W-FFLAGS_W){1'b0}}, frm, fflags_now};
      default: begin
        // Trap registers, or zero for unknown
        if (trap_hit) begin
          rd = trap_rdata;
        end else begin
          rd = '0;
        end
      end
    endcase
  end

  assign req.rdata = rd;

  // ==================================================
  // Write value
  // ==================================================
  always_comb begin
    case (req.op)
      CSR_RW, CSR_RWI: req.write_value = req.wdata;        // Replace
      CSR_RS, CSR_RSI: req.write_value = rd | req.wdata;   // Set bits
      CSR_RC, CSR_RCI: req.write_value = rd & ~req.wdata;  // Clear bits
      default:         req.write_value = rd;               // No change
    endcase
  end

endmodule

// ==== src/csr_req_if.sv ====
/*
 * One CSR request as seen inside the CSR block: address, operand and
 * operation in, read data and the computed write value out, plus the
 * write commit from the access checker.
 */
interface csr_req_if;
  import csr_pkg::*;

  logic [11:0] addr;         // Raw address, may be unknown
  word_t       wdata;        // rs1 value or zero-extended uimm
  csr_op_e     op;
  word_t       rdata;        // Combinational read
  word_t       write_value;  // Value after RW/RS/RC
  logic        commit;       // Write goes ahead this cycle

  // Read mux and write value
  modport read (
    input  addr, wdata, op,
    output rdata, write_value
  );

  modport check (
    input  addr,
    output commit
  );

  // Register holders
  modport reg_side (
    input addr, commit, write_value
  );

endinterface

// ==== src/csr_status_reg.sv ====
/*
 * mstatus register. Handles trap entry into M or S mode, MRET, SRET
 * and CSR writes through mstatus or its sstatus view.
 */
module csr_status_reg (
  input  logic           clk,
  input  logic           reset_n,
  csr_req_if.reg_side    req,
  input  logic           m_entry,       // Trap taken into M
  input  logic           s_entry,       // Trap taken into S
  input  logic           mret,
  input  logic           sret,
  input  csr_pkg::priv_e current_priv,
  output csr_pkg::word_t mstatus_val,
  output logic           mstatus_mie,
  output logic [1:0]     mpp_out,
  output logic           spp_out
);
  import csr_pkg::*;

  word_t mstatus_r;
  word_t wv;

  assign wv = req.write_value;

  // ==================================================
  // mstatus update, trap > mret > sret > write
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus_r <= MSTATUS_RESET;
    end else if (m_entry) begin
      mstatus_r[MSTATUS_MPIE] <= mstatus_r[MSTATUS_MIE];  // Stack MIE
      mstatus_r[MSTATUS_MIE]  <= 1'b0;
      mstatus_r[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB] <= current_priv;
    end else if (s_entry) begin
      mstatus_r[MSTATUS_SPIE] <= mstatus_r[MSTATUS_SIE];  // Stack SIE
      mstatus_r[MSTATUS_SIE]  <= 1'b0;
      mstatus_r[MSTATUS_SPP]  <= current_priv[0];         // U or S
    end else if (mret) begin
      mstatus_r[MSTATUS_MIE]  <= mstatus_r[MSTATUS_MPIE];
      mstatus_r[MSTATUS_MPIE] <= 1'b1;
      mstatus_r[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB] <= PRIV_U;  // Least privileged
    end else if (sret) begin
      mstatus_r[MSTATUS_SIE]  <= mstatus_r[MSTATUS_SPIE];
      mstatus_r[MSTATUS_SPIE] <= 1'b1;
      mstatus_r[MSTATUS_SPP]  <= 1'b0;
    end else if (req.commit) begin
      if (req.addr == CSR_MSTATUS) begin
        // Only the implemented fields take the write
        mstatus_r[MSTATUS_SIE]  <= wv[MSTATUS_SIE];
        mstatus_r[MSTATUS_MIE]  <= wv[MSTATUS_MIE];
        mstatus_r[MSTATUS_SPIE] <= wv[MSTATUS_SPIE];
        mstatus_r[MSTATUS_MPIE] <= wv[MSTATUS_MPIE];
        mstatus_r[MSTATUS_SPP]  <= wv[MSTATUS_SPP];
        mstatus_r[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB] <=
          wv[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB];
      end else if (req.addr == CSR_SSTATUS) begin
        // S-mode view touches masked bits only
        mstatus_r <= (mstatus_r & ~SSTATUS_MASK) | (wv & SSTATUS_MASK);
      end
    end
  end

  // ==================================================
  // Field outputs
  // ==================================================
  assign mstatus_val = mstatus_r;
  assign mstatus_mie = mstatus_r[MSTATUS_MIE];
  assign mpp_out     = mstatus_r[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB];
  assign spp_out     = mstatus_r[MSTATUS_SPP];

endmodule

// ==== src/csr_trap_regs.sv ====
/*
 * Trap registers for M and S mode: tvec, scratch, epc, cause, tval and
 * medeleg. Picks the trap target mode from medeleg, loads the target's
 * epc/cause/tval on entry and serves the matching readback.
 */
module csr_trap_regs (
  input  logic           clk,
  input  logic           reset_n,
  csr_req_if.reg_side    req,
  input  logic           trap_entry,
  input  csr_pkg::word_t trap_pc,
  input  logic [4:0]     trap_cause,    // Exception code
  input  csr_pkg::word_t trap_val,
  input  csr_pkg::priv_e current_priv,
  output csr_pkg::priv_e trap_target_priv,
  output csr_pkg::word_t trap_vector,
  output csr_pkg::word_t mepc_out,
  output csr_pkg::word_t sepc_out,
  output logic           m_entry,
  output logic           s_entry,
  output csr_pkg::word_t trap_rdata,
  output logic           trap_hit
);
  import csr_pkg::*;

  word_t mtvec_r, mscratch_r, mepc_r, mcause_r, mtval_r, medeleg_r;
  word_t stvec_r, sscratch_r, sepc_r, scause_r, stval_r;
  word_t wv;

  assign wv = req.write_value;

  // ==================================================
  // Target mode
  // ==================================================
  // M-mode traps never delegate
  assign trap_target_priv = (current_priv != PRIV_M && medeleg_r[trap_cause]) ? PRIV_S : PRIV_M;

  assign m_entry     = trap_entry && (trap_target_priv == PRIV_M);
  assign s_entry     = trap_entry && (trap_target_priv == PRIV_S);
  assign trap_vector = (trap_target_priv == PRIV_S) ? stvec_r : mtvec_r;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtvec_r    <= '0;
      mscratch_r <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
      medeleg_r  <= '0;  // No delegation
      stvec_r    <= '0;
      sscratch_r <= '0;
      sepc_r     <= '0;
      scause_r   <= '0;
      stval_r    <= '0;
    end else if (s_entry) begin
      sepc_r   <= trap_pc;
      scause_r <= {{(XLEN-5){1'b0}}, trap_cause};
      stval_r  <= trap_val;
    end else if (m_entry) begin
      mepc_r   <= trap_pc;
      mcause_r <= {{(XLEN-5){1'b0}}, trap_cause};
      mtval_r  <= trap_val;
    end else if (req.commit) begin
      case (req.addr)
        CSR_MTVEC:    mtvec_r    <= {wv[XLEN-1:2], 2'b00};  // 4-byte aligned
        CSR_MSCRATCH: mscratch_r <= wv;
        CSR_MEPC:     mepc_r     <= {wv[XLEN-1:1], 1'b0};   // 2-byte for RVC
        CSR_MCAUSE:   mcause_r   <= wv;
        CSR_MTVAL:    mtval_r    <= wv;
        CSR_MEDELEG:  medeleg_r  <= wv;
        CSR_STVEC:    stvec_r    <= {wv[XLEN-1:2], 2'b00};
        CSR_SSCRATCH: sscratch_r <= wv;
        CSR_SEPC:     sepc_r     <= {wv[XLEN-1:1], 1'b0};
        CSR_SCAUSE:   scause_r   <= wv;
        CSR_STVAL:    stval_r    <= wv;
        default: ;  // Not ours
      endcase
    end
  end

  // ==================================================
  // Readback
  // ==================================================
  always_comb begin
    trap_hit = 1'b1;
    case (req.addr)
      CSR_MTVEC:    trap_rdata = mtvec_r;
      CSR_MSCRATCH: trap_rdata = mscratch_r;
      CSR_MEPC:     trap_rdata = mepc_r;
      CSR_MCAUSE:   trap_rdata = mcause_r;
      CSR_MTVAL:    trap_rdata = mtval_r;
      CSR_MEDELEG:  trap_rdata = medeleg_r;
      CSR_STVEC:    trap_rdata = stvec_r;
      CSR_SSCRATCH: trap_rdata = sscratch_r;
      CSR_SEPC:     trap_rdata = sepc_r;
      CSR_SCAUSE:   trap_rdata = scause_r;
      CSR_STVAL:    trap_rdata = stval_r;
      default: begin
        trap_hit   = 1'b0;
        trap_rdata = '0;
      end
    endcase
  end

  assign mepc_out = mepc_r;
  assign sepc_out = sepc_r;

endmodule

// ==== verif/csr_file_tb.sv ====
/*
 * Testbench for the RV32 CSR block. Drives CSR accesses, traps, returns
 * and FPU flag pulses, and checks the responses against a small model.
 */
module csr_file_tb;
  import csr_pkg::*;

  localparam int TB_SEED    = 76;
  localparam int CLK_PERIOD = 100;
  localparam int MAX_CYCLES = 400;  // Several times the stimulus length

  logic        clk, reset_n;
  logic [11:0] csr_addr;
  word_t       csr_wdata, csr_rdata, trap_pc, trap_val, trap_vector, mepc_out, sepc_out;
  logic [2:0]  csr_op, frm_out;
  logic        csr_we, csr_access, illegal_csr, trap_entry, mret, sret;
  logic [4:0]  trap_cause, fflags_in, fflags_out;
  logic [1:0]  trap_target_priv, current_priv, mpp_out;
  logic        mstatus_mie, spp_out, fflags_we;

  int errors = 0;
  int cycles = 0;

  // Reference model state
  word_t      m_scratch, m_tvec, m_stvec;
  logic       m_mie, m_mpie, m_sie, m_spie, m_spp;
  logic [1:0] m_mpp;
  logic [4:0] m_fflags;

  csr_op_e ops [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

  csr_tb_clock #(.PERIOD(CLK_PERIOD)) clock_gen (.clk(clk));

  csr_file csr_file_i (
    .clk(clk), .reset_n(reset_n), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
    .csr_op(csr_op), .csr_we(csr_we), .csr_access(csr_access), .csr_rdata(csr_rdata),
    .illegal_csr(illegal_csr), .trap_entry(trap_entry), .trap_pc(trap_pc),
    .trap_cause(trap_cause), .trap_val(trap_val), .trap_vector(trap_vector),
    .trap_target_priv(trap_target_priv), .mret(mret), .sret(sret),
    .current_priv(current_priv), .mepc_out(mepc_out), .sepc_out(sepc_out),
    .mstatus_mie(mstatus_mie), .mpp_out(mpp_out), .spp_out(spp_out),
    .fflags_we(fflags_we), .fflags_in(fflags_in), .frm_out(frm_out),
    .fflags_out(fflags_out)
  );

  // ==================================================
  // Checks and model helpers
  // ==================================================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Result of a CSR op from the funct3 rules
  function automatic word_t apply_op(input csr_op_e op, input word_t old, input word_t data);
    case (op)
      CSR_RW, CSR_RWI: return data;
      CSR_RS, CSR_RSI: return old | data;
      CSR_RC, CSR_RCI: return old & ~data;
      default:         return old;
    endcase
  endfunction

  function automatic word_t mstatus_model();
    return (32'(m_mpp) << MSTATUS_MPP_LSB) | (32'(m_spp) << MSTATUS_SPP) |
           (32'(m_mpie) << MSTATUS_MPIE) | (32'(m_spie) << MSTATUS_SPIE) |
           (32'(m_mie) << MSTATUS_MIE) | (32'(m_sie) << MSTATUS_SIE);
  endfunction

  // ==================================================
  // Stimulus helpers, all driven on the falling edge
  // ==================================================
  task automatic set_defaults();
    csr_addr     = 12'h7C0;  // Unknown address with access low
    csr_wdata    = '0;
    csr_op       = CSR_RS;
    csr_we       = 1'b0;
    csr_access   = 1'b0;
    trap_entry   = 1'b0;
    trap_pc      = '0;
    trap_cause   = '0;
    trap_val     = '0;
    mret         = 1'b0;
    sret         = 1'b0;
    current_priv = PRIV_M;
    fflags_we    = 1'b0;
    fflags_in    = '0;
  endtask

  task automatic idle();
    @(negedge clk);
    set_defaults();
  endtask

  task automatic settle();
    #(CLK_PERIOD/4);  // Comb outputs stable well before the rising edge
  endtask

  task automatic drive_csr(input logic [11:0] addr, input csr_op_e op, input word_t data,
                           input logic we, input priv_e priv);
    @(negedge clk);
    csr_addr     = addr;
    csr_op       = op;
    csr_wdata    = data;
    csr_we       = we;
    csr_access   = 1'b1;
    current_priv = priv;
  endtask

  task automatic write_csr(input logic [11:0] addr, input csr_op_e op, input word_t data);
    drive_csr(addr, op, data, 1'b1, PRIV_M);
    idle();
  endtask

  task automatic read_expect(input string name, input logic [11:0] addr, input word_t exp);
    drive_csr(addr, CSR_RS, '0, 1'b0, PRIV_M);
    settle();
    check_word(name, csr_rdata, exp);
    check_word("illegal_csr", 32'(illegal_csr), 32'd0);
    idle();
  endtask

  task automatic expect_illegal(input logic [11:0] addr, input logic we, input priv_e priv);
    drive_csr(addr, CSR_RW, $urandom, we, priv);
    settle();
    check_word("illegal_csr", 32'(illegal_csr), 32'd1);
    idle();
  endtask

  task automatic drive_trap(input word_t pc, input logic [4:0] cause, input word_t val,
                            input priv_e priv);
    @(negedge clk);
    trap_entry   = 1'b1;
    trap_pc      = pc;
    trap_cause   = cause;
    trap_val     = val;
    current_priv = priv;
    settle();
  endtask

  task automatic pulse_flags(input logic [4:0] flags);
    @(negedge clk);
    fflags_we = 1'b1;
    fflags_in = flags;
    idle();
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    word_t   data;
    word_t   pc;
    csr_op_e op;
    void'($urandom(TB_SEED));
    set_defaults();
    reset_n   = 1'b0;
    m_scratch = '0;
    m_tvec    = '0;
    m_stvec   = '0;
    {m_mie, m_mpie, m_sie, m_spie, m_spp} = '0;
    m_mpp     = PRIV_M;  // Reset MPP
    m_fflags  = '0;
    repeat (5) @(posedge clk);
    check_word("illegal_csr", 32'(illegal_csr), 32'd0);  // Access low in reset
    @(negedge clk);
    reset_n = 1'b1;

    // Reset values
    read_expect("mstatus", CSR_MSTATUS, MSTATUS_RESET);
    read_expect("misa", CSR_MISA, MISA_VALUE);
    read_expect("mimpid", CSR_MIMPID, MIMPID_VALUE);
    read_expect("mtvec", CSR_MTVEC, '0);
    read_expect("mepc", CSR_MEPC, '0);
    check_word("illegal_csr", 32'(illegal_csr), 32'd0);

    // Read-modify-write on mscratch
    foreach (ops[i]) begin
      op   = ops[i];
      data = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? ($urandom % 32) : $urandom;
      drive_csr(CSR_MSCRATCH, op, data, 1'b1, PRIV_M);
      settle();
      check_word("csr_rdata", csr_rdata, m_scratch);  // Old value until the edge
      idle();
      m_scratch = apply_op(op, m_scratch, data);
      read_expect("mscratch", CSR_MSCRATCH, m_scratch);
    end
    data = $urandom | 32'h3;  // Low bits set so alignment shows
    write_csr(CSR_MTVEC, CSR_RW, data);
    m_tvec = data & ~32'h3;
    read_expect("mtvec", CSR_MTVEC, m_tvec);
    data = $urandom | 32'h1;
    write_csr(CSR_MEPC, CSR_RW, data);
    read_expect("mepc", CSR_MEPC, data & ~32'h1);
    check_word("mepc_out", mepc_out, data & ~32'h1);

    // Illegal accesses
    expect_illegal(12'h7C0, 1'b0, PRIV_M);
    expect_illegal(CSR_MSTATUS, 1'b0, PRIV_S);
    expect_illegal(CSR_MISA, 1'b1, PRIV_M);
    read_expect("misa", CSR_MISA, MISA_VALUE);

    // Machine trap from U, then MRET
    write_csr(CSR_MSTATUS, CSR_RW, 32'h0000_1808);  // MIE set, MPP = M
    m_mie = 1'b1;
    read_expect("mstatus", CSR_MSTATUS, mstatus_model());
    pc   = $urandom;
    data = $urandom;
    drive_trap(pc, 5'd2, data, PRIV_U);
    check_word("trap_target_priv", 32'(trap_target_priv), 32'(PRIV_M));
    check_word("trap_vector", trap_vector, m_tvec);
    idle();
    m_mpie = m_mie;
    m_mie  = 1'b0;
    m_mpp  = PRIV_U;
    check_word("mepc_out", mepc_out, pc);
    check_word("mstatus_mie", 32'(mstatus_mie), 32'(m_mie));
    check_word("mpp_out", 32'(mpp_out), 32'(m_mpp));
    read_expect("mcause", CSR_MCAUSE, 32'd2);
    read_expect("mtval", CSR_MTVAL, data);
    write_csr(CSR_MSTATUS, CSR_RS, 32'h0000_1800);  // MPP back to M before MRET
    m_mpp = PRIV_M;
    @(negedge clk);
    mret = 1'b1;
    idle();
    m_mie  = m_mpie;
    m_mpie = 1'b1;
    m_mpp  = PRIV_U;
    check_word("mstatus_mie", 32'(mstatus_mie), 32'(m_mie));
    check_word("mpp_out", 32'(mpp_out), 32'(m_mpp));
    read_expect("mstatus", CSR_MSTATUS, mstatus_model());

    // Delegated trap from S, same cause from M, then SRET
    write_csr(CSR_MEDELEG, CSR_RS, 32'h0000_2000);  // Cause 13
    read_expect("medeleg", CSR_MEDELEG, 32'h0000_2000);
    data = $urandom;
    write_csr(CSR_STVEC, CSR_RW, data);
    m_stvec = data & ~32'h3;
    read_expect("stvec", CSR_STVEC, m_stvec);
    write_csr(CSR_SSTATUS, CSR_RS, 32'h0000_0002);
    m_sie = 1'b1;
    read_expect("sstatus", CSR_SSTATUS, mstatus_model() & SSTATUS_MASK);
    pc = $urandom;
    drive_trap(pc, 5'd13, $urandom, PRIV_S);
    check_word("trap_target_priv", 32'(trap_target_priv), 32'(PRIV_S));
    check_word("trap_vector", trap_vector, m_stvec);
    idle();
    m_spie = m_sie;
    m_sie  = 1'b0;
    m_spp  = 1'b1;
    check_word("sepc_out", sepc_out, pc);
    check_word("spp_out", 32'(spp_out), 32'(m_spp));
    read_expect("scause", CSR_SCAUSE, 32'd13);
    data = $urandom;
    drive_trap(data, 5'd13, '0, PRIV_M);  // M never delegates
    check_word("trap_target_priv", 32'(trap_target_priv), 32'(PRIV_M));
    check_word("trap_vector", trap_vector, m_tvec);
    idle();
    m_mpie = m_mie;
    m_mie  = 1'b0;
    m_mpp  = PRIV_M;
    check_word("mepc_out", mepc_out, data);
    check_word("sepc_out", sepc_out, pc);
    check_word("mpp_out", 32'(mpp_out), 32'(m_mpp));
    @(negedge clk);
    sret = 1'b1;
    idle();
    m_sie  = m_spie;
    m_spie = 1'b1;
    m_spp  = 1'b0;
    check_word("spp_out", 32'(spp_out), 32'(m_spp));
    read_expect("mstatus", CSR_MSTATUS, mstatus_model());

    // Floating-point rounding mode and flags
    write_csr(CSR_FRM, CSR_RWI, 32'h3);
    read_expect("frm", CSR_FRM, 32'h3);
    check_word("frm_out", 32'(frm_out), 32'h3);
    data = $urandom % 256;
    write_csr(CSR_FCSR, CSR_RW, data);
    m_fflags = data[4:0];
    read_expect("fcsr", CSR_FCSR, data);
    check_word("frm_out", 32'(frm_out), 32'(data[7:5]));
    check_word("fflags_out", 32'(fflags_out), 32'(m_fflags));
    write_csr(CSR_FFLAGS, CSR_RW, '0);
    m_fflags = '0;
    pulse_flags(5'b00001);
    pulse_flags(5'b10000);
    m_fflags = 5'b10001;  // Sticky OR of both pulses
    check_word("fflags_out", 32'(fflags_out), 32'(m_fflags));
    drive_csr(CSR_FFLAGS, CSR_RS, '0, 1'b0, PRIV_M);
    fflags_we = 1'b1;
    fflags_in = 5'b00100;
    settle();
    check_word("csr_rdata", csr_rdata, 32'(m_fflags | 5'b00100));  // Forwarded
    idle();
    m_fflags = m_fflags | 5'b00100;
    check_word("fflags_out", 32'(fflags_out), 32'(m_fflags));
    drive_csr(CSR_FFLAGS, CSR_RW, 32'h2, 1'b1, PRIV_M);
    fflags_we = 1'b1;
    fflags_in = 5'b01000;
    idle();
    m_fflags = 5'b00010;  // Write beats the pulse
    check_word("fflags_out", 32'(fflags_out), 32'(m_fflags));
    read_expect("fflags", CSR_FFLAGS, 32'(m_fflags));

    $display("Errors: %0d, cycles run: %0d", errors, cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/csr_tb_clock.sv ====
/*
 * Testbench clock generator, free running from time zero.
 */
module csr_tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD/2) clk = ~clk;  // Half period per toggle

endmodule
